/* verilog/overlay_defines.svh */
`ifndef OVERLAY_DEFINES_SVH
`define OVERLAY_DEFINES_SVH

// ------------------------------
// horizontal raster, in pixels
// ------------------------------
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  800

// ------------------------------
// vertical raster, in lines
// ------------------------------
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  525

// thermal image, 8x8 screen pixels per sensor pixel
`define THERM_W     32
`define THERM_H     24
`define THERM_SHIFT 3
`define FB_DEPTH    768

// host bus byte address
`define WB_ADR_W 10

`endif

/* verilog/overlay_pkg.sv */
package overlay_pkg;

    // ------------------------------
    // pixel colour
    // ------------------------------
    // one byte per channel, 24 bits in total
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } t_rgb;

    // ------------------------------
    // sync side band
    // ------------------------------
    // hsync and vsync are active low
    // de is the lsb, the delay line reset value relies on it
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } t_sync;

    // ------------------------------
    // raster coordinate
    // ------------------------------
    // 10 bits covers both 800 columns and 525 lines
    typedef logic [9:0] t_pos;

endpackage

/* verilog/video_timing.sv */
`timescale 1ns/1ps
`include "overlay_defines.svh"

module video_timing (
    input  logic                 i_clk,
    input  logic                 i_rst,
    output overlay_pkg::t_pos    o_x,
    output overlay_pkg::t_pos    o_y,
    output overlay_pkg::t_sync   o_sync
);

    // next raster position
    overlay_pkg::t_pos s_h_next;
    overlay_pkg::t_pos s_v_next;

    // sync and de for one raster position
    function automatic overlay_pkg::t_sync f_decode(
        input overlay_pkg::t_pos h,
        input overlay_pkg::t_pos v
    );
        overlay_pkg::t_sync v_sync;
        v_sync.de    = (h < `H_ACTIVE) && (v < `V_ACTIVE);
        // pulse sits after the front porch
        v_sync.hsync = !((h >= `H_ACTIVE + `H_FRONT) &&
                         (h < `H_ACTIVE + `H_FRONT + `H_SYNC));
        v_sync.vsync = !((v >= `V_ACTIVE + `V_FRONT) &&
                         (v < `V_ACTIVE + `V_FRONT + `V_SYNC));
        return v_sync;
    endfunction

    // ------------------------------
    // counters
    // ------------------------------
    always_comb begin
        s_h_next = o_x + 1'b1;
        s_v_next = o_y;
        // end of line, step the line counter
        if (o_x == `H_TOTAL - 1) begin
            s_h_next = '0;
            s_v_next = o_y + 1'b1;
            if (o_y == `V_TOTAL - 1) begin
                s_v_next = '0;
            end
        end
    end

    // sync decoded from the next position
    // keeps it in step with o_x and o_y
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_x    <= '0;
            o_y    <= '0;
            o_sync <= f_decode('0, '0);
        end else begin
            o_x    <= s_h_next;
            o_y    <= s_v_next;
            o_sync <= f_decode(s_h_next, s_v_next);
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_col_range : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_x < `H_TOTAL
    );

endmodule

/* verilog/thermal_framebuffer.sv */
`timescale 1ns/1ps
`include "overlay_defines.svh"

module thermal_framebuffer (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [`WB_ADR_W-1:0]  i_wb_adr,
    input  logic [7:0]            i_wb_dat,
    output logic [7:0]            o_wb_dat,
    output logic                  o_wb_ack,
    input  overlay_pkg::t_pos     i_rd_x,
    input  overlay_pkg::t_pos     i_rd_y,
    output logic [7:0]            o_rd_data
);

    logic [7:0] s_mem [`FB_DEPTH];

    logic s_req;
    logic s_in_range;

    overlay_pkg::t_pos s_blk_col;
    overlay_pkg::t_pos s_blk_row;
    logic [`WB_ADR_W-1:0] s_rd_addr;

    // ------------------------------
    // wishbone slave
    // ------------------------------
    // new request only, not the ack cycle
    assign s_req      = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign s_in_range = (i_wb_adr < `FB_DEPTH);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= s_req;
        end
    end

    always_ff @(posedge i_clk) begin
        // out of range writes dropped
        if (s_req && i_wb_we && s_in_range) begin
            s_mem[i_wb_adr] <= i_wb_dat;
        end
        // valid together with ack
        if (s_req) begin
            o_wb_dat <= s_in_range ? s_mem[i_wb_adr] : 8'h00;
        end
    end

    // ------------------------------
    // video read port
    // ------------------------------
    // 8x8 blocks, mirrored left to right
    always_comb begin
        s_blk_col = i_rd_x >> `THERM_SHIFT;
        s_blk_row = i_rd_y >> `THERM_SHIFT;
        if ((s_blk_col < `THERM_W) && (s_blk_row < `THERM_H)) begin
            s_rd_addr = `WB_ADR_W'(s_blk_row * `THERM_W + (`THERM_W - 1) - s_blk_col);
        end else begin
            // outside the grid, masked in the mixer
            s_rd_addr = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd_data <= s_mem[s_rd_addr];
    end

    // ------------------------------
    // bus checks
    // ------------------------------
    a_ack_needs_req : assert property (
        @(posedge i_clk) disable iff (i_rst)
        $rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb)
    );

    a_ack_single : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_wb_ack |=> !o_wb_ack
    );

endmodule

/* verilog/test_pattern.sv */
`timescale 1ns/1ps
`include "overlay_defines.svh"

module test_pattern (
    input  logic                i_clk,
    input  logic                i_rst,
    input  overlay_pkg::t_pos   i_x,
    output overlay_pkg::t_rgb   o_rgb
);

    // eight bars over the active width
    localparam int c_bar_w = `H_ACTIVE / 8;

    logic [2:0] s_bar;

    // ------------------------------
    // bar index
    // ------------------------------
    // blanking columns wrap around and are never shown
    assign s_bar = 3'(i_x / c_bar_w);

    // bit 2 red, bit 1 green, bit 0 blue
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rgb <= '0;
        end else begin
            o_rgb.r <= {8{s_bar[2]}};
            o_rgb.g <= {8{s_bar[1]}};
            o_rgb.b <= {8{s_bar[0]}};
        end
    end

endmodule

/* verilog/video_delay.sv */
`timescale 1ns/1ps

module video_delay #(
    parameter type t_payload = logic,
    parameter int  p_depth   = 1
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  t_payload i_data,
    output t_payload o_data
);

    // every bit set but the lsb
    // idle sync for t_sync, a cleared flag for one bit
    localparam t_payload c_rst_val = t_payload'({$bits(t_payload){1'b1}} << 1);

    t_payload s_pipe [p_depth];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < p_depth; i++) begin
                s_pipe[i] <= c_rst_val;
            end
        end else begin
            s_pipe[0] <= i_data;
            for (int i = 1; i < p_depth; i++) begin
                s_pipe[i] <= s_pipe[i-1];
            end
        end
    end

    assign o_data = s_pipe[p_depth-1];

endmodule

/* verilog/overlay_mixer.sv */
`timescale 1ns/1ps
`include "overlay_defines.svh"

module overlay_mixer (
    input  logic                i_clk,
    input  logic                i_rst,
    input  overlay_pkg::t_pos   i_x,
    input  overlay_pkg::t_pos   i_y,
    input  logic                i_de,
    input  logic [7:0]          i_therm,
    input  overlay_pkg::t_rgb   i_bg,
    output overlay_pkg::t_rgb   o_rgb
);

    logic s_win;
    logic s_win_d;

    // ------------------------------
    // window
    // ------------------------------
    // 256x192 in the top left corner
    assign s_win = (i_x < (`THERM_W << `THERM_SHIFT)) &&
                   (i_y < (`THERM_H << `THERM_SHIFT));

    // one stage, lines up with frame buffer data
    video_delay #(
        .t_payload (logic),
        .p_depth   (1)
    ) win_delay_i (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_data (s_win),
        .o_data (s_win_d)
    );

    // ------------------------------
    // pixel select
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rgb <= '0;
        end else if (!i_de) begin
            // black in blanking
            o_rgb <= '0;
        end else if (s_win_d) begin
            // gray, same byte on every channel
            o_rgb <= '{r: i_therm, g: i_therm, b: i_therm};
        end else begin
            o_rgb <= i_bg;
        end
    end

endmodule

/* verilog/thermal_overlay_top.sv */
`timescale 1ns/1ps
`include "overlay_defines.svh"

module thermal_overlay_top (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [`WB_ADR_W-1:0]  i_wb_adr,
    input  logic [7:0]            i_wb_dat,
    output logic [7:0]            o_wb_dat,
    output logic                  o_wb_ack,
    output overlay_pkg::t_rgb     o_rgb,
    output logic                  o_hsync,
    output logic                  o_vsync,
    output logic                  o_de
);

    logic s_clk_pixel;

    overlay_pkg::t_pos  s_x;
    overlay_pkg::t_pos  s_y;
    overlay_pkg::t_sync s_sync;
    overlay_pkg::t_sync s_sync_d1;
    overlay_pkg::t_sync s_sync_d2;
    overlay_pkg::t_rgb  s_bg;
    logic [7:0]         s_therm;

    assign s_clk_pixel = i_clk;

    // ------------------------------
    // raster and sources
    // ------------------------------
    video_timing video_timing_i (
        .i_clk  (s_clk_pixel),
        .i_rst  (i_rst),
        .o_x    (s_x),
        .o_y    (s_y),
        .o_sync (s_sync)
    );

    // frame buffer and pattern run side by side
    thermal_framebuffer thermal_framebuffer_i (
        .i_clk     (s_clk_pixel),
        .i_rst     (i_rst),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .i_rd_x    (s_x),
        .i_rd_y    (s_y),
        .o_rd_data (s_therm)
    );

    test_pattern test_pattern_i (
        .i_clk (s_clk_pixel),
        .i_rst (i_rst),
        .i_x   (s_x),
        .o_rgb (s_bg)
    );

    // ------------------------------
    // sync alignment and mix
    // ------------------------------
    // first tap feeds the mixer de
    video_delay #(
        .t_payload (overlay_pkg::t_sync),
        .p_depth   (1)
    ) sync_delay_mix_i (
        .i_clk  (s_clk_pixel),
        .i_rst  (i_rst),
        .i_data (s_sync),
        .o_data (s_sync_d1)
    );

    overlay_mixer overlay_mixer_i (
        .i_clk   (s_clk_pixel),
        .i_rst   (i_rst),
        .i_x     (s_x),
        .i_y     (s_y),
        .i_de    (s_sync_d1.de),
        .i_therm (s_therm),
        .i_bg    (s_bg),
        .o_rgb   (o_rgb)
    );

    // second tap, in step with the registered pixel
    video_delay #(
        .t_payload (overlay_pkg::t_sync),
        .p_depth   (1)
    ) sync_delay_out_i (
        .i_clk  (s_clk_pixel),
        .i_rst  (i_rst),
        .i_data (s_sync_d1),
        .o_data (s_sync_d2)
    );

    assign o_hsync = s_sync_d2.hsync;
    assign o_vsync = s_sync_d2.vsync;
    assign o_de    = s_sync_d2.de;

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int p_half_period = 50,
    parameter int p_rst_cycles  = 5
) (
    output logic o_clk,
    output logic o_rst
);

    // pixel clock, 100 ns period
    initial begin
        o_clk = 1'b0;
        forever #(p_half_period) o_clk = ~o_clk;
    end

    // reset held for the first rising edges, released just after the last one
    initial begin
        o_rst = 1'b1;
        repeat (p_rst_cycles) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

/* testbench/tb_thermal_overlay.sv */
`timescale 1ns/1ps
`include "overlay_defines.svh"

module tb_thermal_overlay;

    localparam int c_ack_wait   = 8;
    localparam int c_rst_wait   = 20;
    localparam int c_frame_wait = `H_TOTAL * `V_TOTAL + 100;
    localparam int c_win_w      = `THERM_W << `THERM_SHIFT;
    localparam int c_win_h      = `THERM_H << `THERM_SHIFT;
    localparam int c_far        = 1000000;
    // error classes
    localparam int c_bus    = 0;
    localparam int c_raster = 1;

    logic s_clk_pixel;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic wb_ack;
    overlay_pkg::t_rgb rgb;
    logic hsync;
    logic vsync;
    logic de;

    // expected frame buffer contents
    logic [7:0] fb_model [`FB_DEPTH];
    logic rd_check;
    logic [7:0] rd_exp;
    logic win_check;
    int bus_errs, raster_errs, pixel_errs, reset_errs, timeouts;

    // tracker state describes the cycle being sampled
    logic rst_d1 = 1'b0;
    logic rst_d2 = 1'b0;
    logic req_prev;
    logic req_lvl;
    logic de_prev, hs_prev, vs_prev, hs_seen;
    int de_run, since_fall, hs_low, hs_period, vs_low, line;
    logic in_win;
    overlay_pkg::t_rgb exp_rgb;

    tb_clock tb_clock_i (
        .o_clk (s_clk_pixel),
        .o_rst (rst)
    );

    thermal_overlay_top thermal_overlay_top_i (
        .i_clk    (s_clk_pixel),
        .i_rst    (rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .o_rgb    (rgb),
        .o_hsync  (hsync),
        .o_vsync  (vsync),
        .o_de     (de)
    );

    // ------------------------------
    // output tracker
    // ------------------------------
    always @(posedge s_clk_pixel) begin
        rst_d1   <= rst;
        rst_d2   <= rst_d1;
        // request raised in the cycle before
        req_prev <= wb_cyc && wb_stb && !req_lvl;
        req_lvl  <= wb_cyc && wb_stb;
        if (rst) begin
            de_prev    <= 1'b0;
            hs_prev    <= 1'b1;
            vs_prev    <= 1'b1;
            hs_seen    <= 1'b0;
            de_run     <= 0;
            since_fall <= c_far;
            hs_low     <= 0;
            hs_period  <= 0;
            vs_low     <= 0;
            line       <= 0;
        end else begin
            de_prev    <= de;
            hs_prev    <= hsync;
            vs_prev    <= vsync;
            // column of the next de cycle
            de_run     <= de ? de_run + 1 : 0;
            since_fall <= (!de && de_prev) ? 1 : since_fall + 1;
            hs_low     <= hsync ? 0 : hs_low + 1;
            vs_low     <= vsync ? 0 : vs_low + 1;
            if (!hsync && hs_prev) begin
                hs_seen   <= 1'b1;
                hs_period <= 1;
            end else begin
                hs_period <= hs_period + 1;
            end
            // active line index restarts at the vsync pulse
            if (!vsync && vs_prev) begin
                line <= 0;
            end else if (!de && de_prev) begin
                line <= line + 1;
            end
        end
    end

    // expected pixel at the tracked position
    always_comb begin
        int bcol;
        int brow;
        int bar;
        logic [7:0] gray;
        bcol = de_run >> `THERM_SHIFT;
        brow = line >> `THERM_SHIFT;
        bar  = de_run / (`H_ACTIVE / 8);
        gray = 8'h00;
        in_win = (de_run < c_win_w) && (line < c_win_h);
        if (in_win) begin
            // mirrored block address
            gray = fb_model[brow * `THERM_W + `THERM_W - 1 - bcol];
            exp_rgb = '{r: gray, g: gray, b: gray};
        end else begin
            exp_rgb.r = bar[2] ? 8'hff : 8'h00;
            exp_rgb.g = bar[1] ? 8'hff : 8'h00;
            exp_rgb.b = bar[0] ? 8'hff : 8'h00;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_ack_timing : assert property (@(posedge s_clk_pixel) disable iff (rst)
        wb_ack == req_prev)
        else count_fail(c_bus, "o_wb_ack", $sampled(req_prev), $sampled(wb_ack));
    a_ack_single : assert property (@(posedge s_clk_pixel) disable iff (rst)
        wb_ack |=> !wb_ack)
        else count_fail(c_bus, "o_wb_ack", 0, 1);
    a_rd_data : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (wb_ack && rd_check) |-> wb_dat_r == rd_exp)
        else count_fail(c_bus, "o_wb_dat", $sampled(rd_exp), $sampled(wb_dat_r));

    a_de_len : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (!de && de_prev) |-> de_run == `H_ACTIVE)
        else count_fail(c_raster, "o_de run", `H_ACTIVE, $sampled(de_run));
    a_hs_start : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (!hsync && hs_prev && since_fall < `H_TOTAL) |-> since_fall == `H_FRONT)
        else count_fail(c_raster, "o_hsync start", `H_FRONT, $sampled(since_fall));
    a_hs_len : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (hsync && !hs_prev) |-> hs_low == `H_SYNC)
        else count_fail(c_raster, "o_hsync width", `H_SYNC, $sampled(hs_low));
    a_line_period : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (!hsync && hs_prev && hs_seen) |-> hs_period == `H_TOTAL)
        else count_fail(c_raster, "o_hsync period", `H_TOTAL, $sampled(hs_period));
    a_lines : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (!vsync && vs_prev) |-> line == `V_ACTIVE)
        else count_fail(c_raster, "o_de lines", `V_ACTIVE, $sampled(line));
    a_vs_len : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (vsync && !vs_prev) |-> vs_low == `V_SYNC * `H_TOTAL)
        else count_fail(c_raster, "o_vsync width", `V_SYNC * `H_TOTAL, $sampled(vs_low));

    a_pix_win : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (de && in_win && win_check) |-> rgb == exp_rgb)
        else pixel_fail($sampled(exp_rgb), $sampled(rgb));
    a_pix_bg : assert property (@(posedge s_clk_pixel) disable iff (rst)
        (de && !in_win) |-> rgb == exp_rgb)
        else pixel_fail($sampled(exp_rgb), $sampled(rgb));
    a_blank : assert property (@(posedge s_clk_pixel) disable iff (rst)
        !de |-> rgb == '0)
        else pixel_fail(24'h0, $sampled(rgb));

    // reset cycles and the one right after
    a_reset_idle : assert property (@(posedge s_clk_pixel)
        (rst_d1 || rst_d2) |-> (!de && hsync && vsync && !wb_ack && rgb == '0))
        else begin
            reset_errs++;
            $display("outputs not idle around reset at t=%0t: de=%b hsync=%b vsync=%b ack=%b",
                     $time, $sampled(de), $sampled(hsync), $sampled(vsync), $sampled(wb_ack));
        end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic count_fail(input int kind, input string sig, input int exp, input int got);
        case (kind)
            c_bus:   bus_errs++;
            default: raster_errs++;
        endcase
        $display("FAIL t=%0t %s expected %0d got %0d", $time, sig, exp, got);
    endtask

    task automatic pixel_fail(input logic [23:0] exp, input logic [23:0] got);
        pixel_errs++;
        $display("FAIL t=%0t o_rgb expected %06h got %06h", $time, exp, got);
    endtask

    task automatic end_run();
        int total;
        total = bus_errs + raster_errs + pixel_errs + reset_errs + timeouts;
        $display("errors bus %0d raster %0d pixel %0d reset %0d timeout %0d",
                 bus_errs, raster_errs, pixel_errs, reset_errs, timeouts);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // one classic cycle with the request driven just after a rising edge
    task automatic bus_cycle(input logic we, input int adr, input logic [7:0] dat,
                             input logic chk, input logic [7:0] exp);
        int n;
        // skipped once any wait has timed out
        if (timeouts != 0) begin
            return;
        end
        @(posedge s_clk_pixel);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = `WB_ADR_W'(adr);
        wb_dat_w = dat;
        rd_check = chk;
        rd_exp   = exp;
        n = 0;
        do begin
            @(posedge s_clk_pixel);
            #1;
            n++;
        end while (!wb_ack && n < c_ack_wait);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("no bus acknowledge for address %0d within %0d cycles", adr, n);
            timeouts++;
        end
    endtask

    task automatic bus_write(input int adr, input logic [7:0] dat);
        bus_cycle(1'b1, adr, dat, 1'b0, 8'h00);
        if (adr < `FB_DEPTH) begin
            fb_model[adr] = dat;
        end
    endtask

    task automatic bus_read(input int adr);
        bus_cycle(1'b0, adr, 8'h00, 1'b1, (adr < `FB_DEPTH) ? fb_model[adr] : 8'h00);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge s_clk_pixel);
            n++;
        end while (rst && n < c_rst_wait);
        if (rst) begin
            $display("reset still asserted after %0d cycles", n);
            timeouts++;
        end
    endtask

    task automatic wait_vsync_fall();
        int n;
        logic prev;
        logic seen;
        // skipped once any wait has timed out
        if (timeouts != 0) begin
            return;
        end
        n = 0;
        prev = vsync;
        do begin
            @(posedge s_clk_pixel);
            #1;
            n++;
            seen = !vsync && prev;
            prev = vsync;
        end while (!seen && n < c_frame_wait);
        if (!seen) begin
            $display("no vsync pulse within %0d cycles", n);
            timeouts++;
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = 8'h00;
        rd_check  = 1'b0;
        rd_exp    = 8'h00;
        win_check = 1'b0;
        void'($urandom(32'he5b29906));
        wait_reset_release();
        // fill the whole buffer
        for (int a = 0; a < `FB_DEPTH; a++) begin
            bus_write(a, 8'($urandom));
        end
        // writes beyond the buffer are dropped
        bus_write(`FB_DEPTH, 8'($urandom));
        bus_write(900, 8'($urandom));
        bus_write(1023, 8'($urandom));
        bus_read(0);
        bus_read(`FB_DEPTH - 1);
        for (int i = 0; i < 48; i++) begin
            bus_read(int'($urandom_range(`FB_DEPTH - 1, 0)));
        end
        bus_read(`FB_DEPTH);
        bus_read(1023);
        // buffer now static so window pixels are comparable
        win_check = 1'b1;
        // sync to a frame start then two full frames
        repeat (3) wait_vsync_fall();
        end_run();
    end

endmodule

/* thermal_overlay_top.f */
+incdir+verilog
verilog/overlay_pkg.sv
verilog/video_timing.sv
verilog/thermal_framebuffer.sv
verilog/test_pattern.sv
verilog/video_delay.sv
verilog/overlay_mixer.sv
verilog/thermal_overlay_top.sv
testbench/tb_clock.sv
testbench/tb_thermal_overlay.sv

/* Makefile */
# Verilator flow for the thermal overlay subsystem

VERILATOR ?= verilator
TOP       ?= tb_thermal_overlay
RTL_TOP   ?= thermal_overlay_top
FILELIST  ?= thermal_overlay_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
